//--- build.f
src/mem_fill_pkg.sv
src/lfsr31.sv
src/mem_randomizer.sv
src/bank_router.sv
src/ram_bank.sv
src/bank_read_mux.sv
src/mem_fill_top.sv
testbench/tb_mem_fill.sv

//--- Makefile
# Verilator build and run of the memory fill testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_mem_fill
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator status is ignored here, the log decides the result
test: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_mem_fill.sv
// Memory fill testbench

`timescale 1ns/1ps

module tb_mem_fill;
	import mem_fill_pkg::*;

	// ========================================
	// Run parameters
	// ========================================

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 3;
	localparam int READ_LATENCY = 2;
	// Edges watched per full fill reach a few past the edge that raises done
	localparam int FILL_EDGES   = NUM_HW + 8;
	// Edges run before the reset that interrupts a fill
	localparam int PART_FILL    = 200;
	localparam int RAND_READS   = 200;
	// Two full readbacks plus the random burst
	localparam int READ_COUNT   = 2 * NUM_LINES + RAND_READS;
	localparam int READ_MARGIN  = 4;
	localparam int WATCHDOG_CYCLES = 3 * (RESET_CYCLES + 1) + 2 * FILL_EDGES + PART_FILL
		+ READ_COUNT * READ_MARGIN;

	// ========================================
	// DUT and bookkeeping
	// ========================================

	logic       clk;
	logic       rst;
	logic       rd;
	line_addr_t rd_line;
	line_data_t rd_data;
	logic       rd_valid;
	logic       done;

	// Rising edges seen since time zero
	int         edge_cnt = 0;
	integer     seed;

	// Outstanding reads in issue order, with the edge that samples each one
	line_addr_t pend_line [$];
	int         pend_edge [$];

	mem_fill_top dut0 (
		.clk      (clk),
		.rst      (rst),
		.rd       (rd),
		.rd_line  (rd_line),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.done     (done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		forever begin
			@(posedge clk);
			edge_cnt++;
		end
	end

	// ========================================
	// Reference model
	// ========================================

	// Line L holds halfwords 8L to 8L+7, halfword k being LFSR state k
	function automatic line_data_t expected_line(input line_addr_t line);
		lfsr_t      st;
		line_data_t val;
		int         k;
		st  = LFSR_SEED;
		val = '0;
		for (k = 0; k < (int'(line) + 1) * HW_PER_LINE; k++) begin
			if (k >= int'(line) * HW_PER_LINE) begin
				val[(k % HW_PER_LINE) * 16 +: 16] = st[15:0];
			end
			// Shift left with the new bit 0 taken from bits 30 and 27
			st = {st[29:0], st[30] ^ st[27]};
		end
		return val;
	endfunction

	// ========================================
	// Error handling and compares
	// ========================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_line(input string name, input line_data_t got, input line_data_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got=%h exp=%h", $time, name, got, exp);
			abort_run("Read data does not match the fill model");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got=%b exp=%b", $time, name, got, exp);
			abort_run("A status output has the wrong level");
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("ERR %0t %s got=%0d exp=%0d", $time, name, got, exp);
			abort_run("A count or latency is wrong");
		end
	endtask

	// ========================================
	// Stimulus helpers
	// ========================================

	// Inputs change a little after the edge so the DUT samples them cleanly
	task automatic next_cycle();
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	// Keeps rst high for the reset cycles then releases it
	task automatic hold_reset();
		repeat (RESET_CYCLES) begin
			next_cycle();
			check_bit("done", done, 1'b0);
			check_bit("rd_valid", rd_valid, 1'b0);
		end
		rst = 1'b0;
	endtask

	// Done is expected low up to edge NUM_HW after release and high from edge NUM_HW+1 on
	task automatic check_fill_timing(input int edges);
		int e;
		for (e = 1; e <= edges; e++) begin
			next_cycle();
			check_bit("done", done, e > NUM_HW);
			if (e == 1) begin
				check_bit("rd_valid", rd_valid, 1'b0);
			end
		end
	endtask

	// The read is sampled on the coming edge, which is logged with it
	task automatic issue_read(input line_addr_t line);
		rd      = 1'b1;
		rd_line = line;
		pend_line.push_back(line);
		pend_edge.push_back(edge_cnt + 1);
		next_cycle();
	endtask

	task automatic read_all_lines();
		int l;
		for (l = 0; l < NUM_LINES; l++) begin
			issue_read(line_addr_t'(l));
		end
		rd = 1'b0;
	endtask

	task automatic read_random_lines(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			issue_read(line_addr_t'($random(seed)));
		end
		rd = 1'b0;
	endtask

	// Every read has to come back within the latency
	task automatic drain_reads();
		int waited;
		waited = 0;
		while (pend_line.size() > 0 && waited < READ_LATENCY + 2) begin
			next_cycle();
			waited++;
		end
		if (pend_line.size() > 0) begin
			abort_run("Reads were still outstanding after the read latency");
		end
	endtask

	// ========================================
	// Read checker
	// ========================================

	// Pairs each rd_valid with the oldest outstanding read
	initial begin : compare_reads
		line_addr_t line;
		int         due;
		forever begin
			@(posedge clk);
			#1;
			if (rd_valid === 1'b1) begin
				if (pend_line.size() == 0) begin
					abort_run("rd_valid pulsed with no read outstanding");
				end else begin
					line = pend_line.pop_front();
					due  = pend_edge.pop_front();
					check_count("rd_valid latency", edge_cnt - due, READ_LATENCY);
					check_line("rd_data", rd_data, expected_line(line));
				end
			end else if (pend_edge.size() > 0 && edge_cnt - pend_edge[0] >= READ_LATENCY) begin
				abort_run("rd_valid did not arrive for an issued read");
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("Watchdog expired before the tests finished");
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin : main_seq
		rst     = 1'b1;
		rd      = 1'b0;
		rd_line = '0;
		seed    = 32'h7250;

		// Outputs stay low in reset and on the first edge after it
		hold_reset();
		check_fill_timing(FILL_EDGES);

		// In-order readback of the whole memory
		read_all_lines();
		drain_reads();

		// Back-to-back reads of random lines
		read_random_lines(RAND_READS);
		drain_reads();

		// The async reset clears done at once
		rst = 1'b1;
		#1;
		check_bit("done", done, 1'b0);
		hold_reset();
		check_fill_timing(PART_FILL);

		// Interrupt the fill part way and let it start over
		rst = 1'b1;
		#1;
		check_bit("done", done, 1'b0);
		hold_reset();
		check_fill_timing(FILL_EDGES);
		read_all_lines();
		drain_reads();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- src/mem_fill_top.sv
// Memory fill subsystem top

`timescale 1ns/1ps

module mem_fill_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     rd,
	input  mem_fill_pkg::line_addr_t rd_line,
	output mem_fill_pkg::line_data_t rd_data,
	output logic                     rd_valid,
	output logic                     done
);
	import mem_fill_pkg::*;

	// ========================================
	// Interconnect
	// ========================================

	lfsr_t                           lfsr_o;
	logic                            wr;
	line_addr_t                      wr_line;
	byte_sel_t                       wr_sel;
	line_data_t                      wr_data;
	logic       [NUM_BANKS-1:0]      bank_wr;
	logic       [NUM_BANKS-1:0]      bank_rd;
	row_addr_t                       bank_wr_row;
	row_addr_t                       bank_rd_row;
	byte_sel_t                       bank_sel;
	line_data_t                      bank_data;
	bank_idx_t                       rd_bank;
	logic                            rd_pend;
	line_data_t [NUM_BANKS-1:0]      bank_q;

	// The LFSR free-runs so state k is seen before edge k+1
	lfsr31 u_lfsr (
		.clk (clk),
		.rst (rst),
		.ce  (1'b1),
		.o   (lfsr_o)
	);

	mem_randomizer u_gen (
		.clk     (clk),
		.rst     (rst),
		.lfsr_o  (lfsr_o),
		.wr      (wr),
		.wr_line (wr_line),
		.wr_sel  (wr_sel),
		.wr_data (wr_data),
		.done    (done)
	);

	bank_router u_router (
		.clk         (clk),
		.rst         (rst),
		.wr          (wr),
		.wr_line     (wr_line),
		.wr_sel      (wr_sel),
		.wr_data     (wr_data),
		.rd          (rd),
		.rd_line     (rd_line),
		.bank_wr     (bank_wr),
		.bank_rd     (bank_rd),
		.bank_wr_row (bank_wr_row),
		.bank_rd_row (bank_rd_row),
		.bank_sel    (bank_sel),
		.bank_data   (bank_data),
		.rd_bank     (rd_bank),
		.rd_pend     (rd_pend)
	);

	// One bank per low line address value
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		ram_bank u_bank (
			.clk    (clk),
			.wr     (bank_wr[b]),
			.rd     (bank_rd[b]),
			.wr_row (bank_wr_row),
			.rd_row (bank_rd_row),
			.sel    (bank_sel),
			.data   (bank_data),
			.q      (bank_q[b])
		);
	end

	bank_read_mux u_merge (
		.clk      (clk),
		.rst      (rst),
		.rd_pend  (rd_pend),
		.rd_bank  (rd_bank),
		.bank_q   (bank_q),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

endmodule

//--- src/bank_read_mux.sv
// Bank read merger

`timescale 1ns/1ps

module bank_read_mux (
	input  logic                                                clk,
	input  logic                                                rst,
	input  logic                                                rd_pend,
	input  mem_fill_pkg::bank_idx_t                             rd_bank,
	input  mem_fill_pkg::line_data_t [mem_fill_pkg::NUM_BANKS-1:0] bank_q,
	output mem_fill_pkg::line_data_t                            rd_data,
	output logic                                                rd_valid
);
	import mem_fill_pkg::*;

	// Pend and bank index one cycle late, in step with the bank q register
	logic       pend_d;
	bank_idx_t  bank_d;
	line_data_t sel_q;

	assign sel_q = bank_q[bank_d];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pend_d   <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			pend_d   <= rd_pend;
			rd_valid <= pend_d;
		end
	end

	// Capture the returning bank's line only when a read is due
	always_ff @(posedge clk) begin
		bank_d <= rd_bank;
		if (pend_d) begin
			rd_data <= sel_q;
		end
	end

endmodule

//--- src/ram_bank.sv
// RAM bank with byte enables

`timescale 1ns/1ps

module ram_bank (
	input  logic                     clk,
	input  logic                     wr,
	input  logic                     rd,
	input  mem_fill_pkg::row_addr_t  wr_row,
	input  mem_fill_pkg::row_addr_t  rd_row,
	input  mem_fill_pkg::byte_sel_t  sel,
	input  mem_fill_pkg::line_data_t data,
	output mem_fill_pkg::line_data_t q
);
	import mem_fill_pkg::*;

	// ========================================
	// Storage
	// ========================================

	line_data_t mem [BANK_ROWS];

	// Only the enabled byte lanes of the row change
	always_ff @(posedge clk) begin
		if (wr) begin
			for (int i = 0; i < $bits(byte_sel_t); i++) begin
				if (sel[i]) begin
					mem[wr_row][i*8 +: 8] <= data[i*8 +: 8];
				end
			end
		end
	end

	// ========================================
	// Read port
	// ========================================

	// Registered read, q holds its value between reads
	// A read of the row being written returns the old contents
	always_ff @(posedge clk) begin
		if (rd) begin
			q <= mem[rd_row];
		end
	end

endmodule

//--- src/bank_router.sv
// Bank router
// Steers writes and reads to the RAM banks

`timescale 1ns/1ps

module bank_router (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 wr,
	input  mem_fill_pkg::line_addr_t             wr_line,
	input  mem_fill_pkg::byte_sel_t              wr_sel,
	input  mem_fill_pkg::line_data_t             wr_data,
	input  logic                                 rd,
	input  mem_fill_pkg::line_addr_t             rd_line,
	output logic [mem_fill_pkg::NUM_BANKS-1:0]   bank_wr,
	output logic [mem_fill_pkg::NUM_BANKS-1:0]   bank_rd,
	output mem_fill_pkg::row_addr_t              bank_wr_row,
	output mem_fill_pkg::row_addr_t              bank_rd_row,
	output mem_fill_pkg::byte_sel_t              bank_sel,
	output mem_fill_pkg::line_data_t             bank_data,
	output mem_fill_pkg::bank_idx_t              rd_bank,
	output logic                                 rd_pend
);
	import mem_fill_pkg::*;

	bank_idx_t wr_idx;
	bank_idx_t rd_idx;

	// Low line bits pick the bank, the rest pick the row
	assign wr_idx = wr_line[1:0];
	assign rd_idx = rd_line[1:0];

	// ========================================
	// Strobes
	// ========================================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bank_wr <= '0;
			bank_rd <= '0;
			rd_pend <= 1'b0;
		end else begin
			bank_wr <= wr ? (NUM_BANKS'(1) << wr_idx) : '0;
			bank_rd <= rd ? (NUM_BANKS'(1) << rd_idx) : '0;
			// Tells the merger a bank output is coming two edges later
			rd_pend <= rd;
		end
	end

	// Rows, lanes and data are shared by all banks
	// Write and read keep their own row so both can go in one cycle
	always_ff @(posedge clk) begin
		bank_wr_row <= wr_line[5:2];
		bank_rd_row <= rd_line[5:2];
		bank_sel    <= wr_sel;
		bank_data   <= wr_data;
		rd_bank     <= rd_idx;
	end

	a_wr_onehot: assert property (
		@(posedge clk) disable iff (rst) $onehot0(bank_wr)
	) else $error("more than one bank written at once");

	a_rd_onehot: assert property (
		@(posedge clk) disable iff (rst) $onehot0(bank_rd)
	) else $error("more than one bank read at once");

endmodule

//--- src/mem_randomizer.sv
// Memory fill write generator
// Walks every halfword and writes LFSR data

`timescale 1ns/1ps

module mem_randomizer (
	input  logic                     clk,
	input  logic                     rst,
	input  mem_fill_pkg::lfsr_t      lfsr_o,
	output logic                     wr,
	output mem_fill_pkg::line_addr_t wr_line,
	output mem_fill_pkg::byte_sel_t  wr_sel,
	output mem_fill_pkg::line_data_t wr_data,
	output logic                     done
);
	import mem_fill_pkg::*;

	fill_state_t state;
	hw_count_t   count;
	logic        count_top;
	logic        issue;

	// The top counter bit sets once all halfwords have been issued
	assign count_top = count[$bits(hw_count_t)-1];
	// A write goes out on every edge until the walk is complete
	assign issue = (state != FILL_DONE) && !count_top;
	assign done = (state == FILL_DONE);

	// ========================================
	// Control
	// ========================================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= FILL_IDLE;
			count <= '0;
			wr    <= 1'b0;
		end else begin
			case (state)
				// The first edge out of reset already issues halfword 0
				FILL_IDLE, FILL_RUN: begin
					if (count_top) begin
						wr    <= 1'b0;
						state <= FILL_DONE;
					end else begin
						wr    <= 1'b1;
						count <= count + 1'b1;
						state <= FILL_RUN;
					end
				end
				// Stay here until the next reset
				default: begin
					wr <= 1'b0;
				end
			endcase
		end
	end

	// ========================================
	// Write payload
	// ========================================

	// Halfword k lands in line k/8 on byte lanes 2(k mod 8) and 2(k mod 8)+1
	always_ff @(posedge clk) begin
		if (issue) begin
			wr_line <= count[8:3];
			wr_sel  <= byte_sel_t'(2'b11) << {count[2:0], 1'b0};
			// Replicate so the selected lanes see the halfword wherever they sit
			wr_data <= {HW_PER_LINE{lfsr_o[15:0]}};
		end
	end

	a_sel_pair: assert property (
		@(posedge clk) disable iff (rst)
		wr |-> ($countones(wr_sel) == 2) && ((wr_sel & (wr_sel >> 1)) != '0)
	) else $error("wr_sel is not a pair of adjacent lanes");

	a_no_wr_done: assert property (
		@(posedge clk) disable iff (rst) (state == FILL_DONE) |-> !wr
	) else $error("write issued after fill completed");

	// Finishing means every halfword was counted exactly once
	a_done_count: assert property (
		@(posedge clk) disable iff (rst) done |-> (count == hw_count_t'(NUM_HW))
	) else $error("fill finished with a wrong halfword count");

endmodule

//--- src/lfsr31.sv
// 31-bit LFSR

`timescale 1ns/1ps

module lfsr31 (
	input  logic                clk,
	input  logic                rst,
	input  logic                ce,
	output mem_fill_pkg::lfsr_t o
);
	import mem_fill_pkg::*;

	// Feedback from taps 31 and 28 gives a maximal-length sequence
	logic fb;

	assign fb = o[30] ^ o[27];

	// Shift left and feed the tap XOR into the bottom bit
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o <= LFSR_SEED;
		end else if (ce) begin
			o <= {o[29:0], fb};
		end
	end

	// The zero state would stall the sequence for good
	a_never_zero: assert property (
		@(posedge clk) disable iff (rst) o != '0
	) else $error("lfsr31 state reached zero");

endmodule

//--- src/mem_fill_pkg.sv
// Memory fill shared definitions
// Geometry, widths and generator states

package mem_fill_pkg;

	// ========================================
	// Memory geometry
	// ========================================

	// Four banks interleaved on the low line address bits
	localparam int NUM_BANKS   = 4;
	localparam int BANK_ROWS   = 16;
	localparam int NUM_LINES   = NUM_BANKS * BANK_ROWS;
	// A 128-bit line holds eight halfwords
	localparam int HW_PER_LINE = 8;
	localparam int NUM_HW      = NUM_LINES * HW_PER_LINE;

	// Any nonzero value works as a seed, the all-zero state locks up
	localparam logic [30:0] LFSR_SEED = 31'd1;

	// ========================================
	// Width types
	// ========================================

	typedef logic [16*HW_PER_LINE-1:0]      line_data_t;
	typedef logic [2*HW_PER_LINE-1:0]       byte_sel_t;
	// Line index with the bank in the low bits and the row above it
	typedef logic [$clog2(NUM_LINES)-1:0]   line_addr_t;
	typedef logic [$clog2(BANK_ROWS)-1:0]   row_addr_t;
	typedef logic [$clog2(NUM_BANKS)-1:0]   bank_idx_t;
	// One extra bit on top flags that the walk has finished
	typedef logic [$clog2(NUM_HW):0]        hw_count_t;
	typedef logic [30:0]                    lfsr_t;

	// Write generator states
	typedef enum logic [1:0] {
		FILL_IDLE,
		FILL_RUN,
		FILL_DONE
	} fill_state_t;

endpackage
